// ==== trace_pkg.sv ====
// --------------------------------------
// Commit trace definitions
// Widths, privilege and mode encodings
// and the entry stored per retired PC
// --------------------------------------

package trace_pkg;

  // --------------------------------------
  // Widths
  // --------------------------------------

  // Program counter width
  localparam int unsigned PcWidth = 64;

  // --------------------------------------
  // Encodings
  // --------------------------------------

  // Privilege level as seen from the CSR file
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Mode label attached to each traced commit
  // D wins over any privilege level
  typedef enum logic [1:0] {
    MODE_M = 2'b00,
    MODE_S = 2'b01,
    MODE_U = 2'b10,
    MODE_D = 2'b11
  } trace_mode_e;

  // --------------------------------------
  // Trace entry
  // --------------------------------------

  // One retired instruction, 66 bits wide
  typedef struct packed {
    logic [PcWidth-1:0] pc;
    trace_mode_e        mode;
  } trace_entry_t;

  // Width of one stored entry
  localparam int unsigned TraceEntryWidth = $bits(trace_entry_t);

endpackage

// ==== commit_filter.sv ====
// --------------------------------------
// Commit filter
// Accepts commits per port, drops the
// trapping ones and tags the rest with
// the current mode
// --------------------------------------

`timescale 1ns/1ps

module commit_filter #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // Commit side
  input  logic [NrCommitPorts-1:0]                            commit_valid_i,
  input  logic [NrCommitPorts-1:0]                            commit_ex_i,
  input  logic [NrCommitPorts-1:0][trace_pkg::PcWidth-1:0]    commit_pc_i,
  input  trace_pkg::priv_lvl_e                                priv_lvl_i,
  input  logic                                                debug_mode_i,
  output logic [NrCommitPorts-1:0]                            commit_ready_o,
  // FIFO side
  input  logic [NrCommitPorts-1:0]                            fifo_full_i,
  output logic [NrCommitPorts-1:0]                            push_o,
  output trace_pkg::trace_entry_t [NrCommitPorts-1:0]         entry_o
);

  import trace_pkg::*;

  trace_mode_e mode;

  // --------------------------------------
  // Mode tag
  // --------------------------------------

  // Shared by all ports in the same cycle
  always_comb begin
    if (debug_mode_i) begin
      mode = MODE_D;
    end else begin
      unique case (priv_lvl_i)
        PRIV_LVL_M: mode = MODE_M;
        PRIV_LVL_S: mode = MODE_S;
        PRIV_LVL_U: mode = MODE_U;
        // Reserved level, label as machine mode
        default:    mode = MODE_M;
      endcase
    end
  end

  // --------------------------------------
  // Per port accept and store
  // --------------------------------------

  // A port takes a commit whenever its FIFO has room
  assign commit_ready_o = ~fifo_full_i;

  // Trapping commits are acknowledged but never stored
  assign push_o = commit_valid_i & commit_ready_o & ~commit_ex_i;

  always_comb begin
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      entry_o[i].pc   = commit_pc_i[i];
      entry_o[i].mode = mode;
    end
  end

  // A stalled commit stays on the port until it is taken
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_hold_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (commit_valid_i[i] && !commit_ready_o[i]) |=> (commit_valid_i[i]
        && $stable(commit_pc_i[i]) && $stable(commit_ex_i[i])))
      else $error("commit_filter: commit withdrawn before it was taken");
  end

endmodule

// ==== trace_fifo.sv ====
// --------------------------------------
// Trace FIFO
// Circular buffer with a generic payload
// One instance per commit port
// --------------------------------------

`timescale 1ns/1ps

module trace_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 16
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Write side
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  // Read side
  input  logic pop_i,
  output logic not_empty_o,
  output T     data_o
);

  localparam int unsigned AddrWidth = $clog2(Depth);

  T                     mem_q [Depth];
  logic [AddrWidth-1:0] wr_ptr_q;
  logic [AddrWidth-1:0] rd_ptr_q;
  logic [AddrWidth:0]   count_q;

  // --------------------------------------
  // Status
  // --------------------------------------

  assign full_o      = (count_q == Depth[AddrWidth:0]);
  assign not_empty_o = (count_q != '0);
  assign data_o      = mem_q[rd_ptr_q];

  // --------------------------------------
  // Pointers and occupancy
  // --------------------------------------

  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        // Both or neither, occupancy unchanged
        default: count_q <= count_q;
      endcase
    end
  end

  // --------------------------------------
  // Storage
  // --------------------------------------

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------

  // Writer must respect full
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o)
    else $error("trace_fifo: push while full");

  // Reader must respect empty
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> not_empty_o)
    else $error("trace_fifo: pop while empty");

endmodule

// ==== trace_arbiter.sv ====
// --------------------------------------
// Trace arbiter
// Round-robin merge of the port FIFOs
// into one registered valid/ready stream
// --------------------------------------

`timescale 1ns/1ps

module trace_arbiter #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned PortIdxWidth  = 1
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // FIFO side
  input  logic [NrCommitPorts-1:0]                    not_empty_i,
  input  trace_pkg::trace_entry_t [NrCommitPorts-1:0] head_i,
  output logic [NrCommitPorts-1:0]                    pop_o,
  // Trace stream
  output logic                                        trace_valid_o,
  input  logic                                        trace_ready_i,
  output logic [trace_pkg::PcWidth-1:0]               trace_pc_o,
  output trace_pkg::trace_mode_e                      trace_mode_o,
  output logic [PortIdxWidth-1:0]                     trace_port_o
);

  import trace_pkg::*;

  // Pointer holds the port after the last grant
  logic [PortIdxWidth-1:0] rr_q;
  logic [PortIdxWidth-1:0] sel_idx;
  logic                    sel_valid;
  logic                    load;

  // Output register
  logic                    valid_q;
  logic [PcWidth-1:0]      pc_q;
  trace_mode_e             mode_q;
  logic [PortIdxWidth-1:0] port_q;

  // --------------------------------------
  // Port selection
  // --------------------------------------

  // First non-empty port at or after the pointer, cyclic
  always_comb begin
    int unsigned idx;
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int unsigned off = 0; off < NrCommitPorts; off++) begin
      idx = (rr_q + off) % NrCommitPorts;
      if (!sel_valid && not_empty_i[idx]) begin
        sel_valid = 1'b1;
        sel_idx   = PortIdxWidth'(idx);
      end
    end
  end

  // Register is free or drains this cycle
  assign load = (!valid_q || trace_ready_i) && sel_valid;

  always_comb begin
    pop_o = '0;
    if (load) begin
      pop_o[sel_idx] = 1'b1;
    end
  end

  // --------------------------------------
  // Pointer and output register
  // --------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q    <= '0;
      valid_q <= 1'b0;
    end else begin
      if (load) begin
        valid_q <= 1'b1;
        if (sel_idx == PortIdxWidth'(NrCommitPorts - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= sel_idx + 1'b1;
        end
      end else if (trace_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      pc_q   <= head_i[sel_idx].pc;
      mode_q <= head_i[sel_idx].mode;
      port_q <= sel_idx;
    end
  end

  assign trace_valid_o = valid_q;
  assign trace_pc_o    = pc_q;
  assign trace_mode_o  = mode_q;
  assign trace_port_o  = port_q;

  // --------------------------------------
  // Checks
  // --------------------------------------

  // A waiting head entry stays put until it is popped
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_head_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (not_empty_i[i] && !pop_o[i]) |=> (not_empty_i[i] && $stable(head_i[i])))
      else $error("trace_arbiter: FIFO head changed before its pop");
  end

  // Stalled output holds its item
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_valid_o && !trace_ready_i) |=> (trace_valid_o && $stable(trace_pc_o)
      && $stable(trace_mode_o) && $stable(trace_port_o)))
    else $error("trace_arbiter: output changed under back-pressure");

endmodule

// ==== commit_tracer.sv ====
// --------------------------------------
// Commit tracer
// Tags retired PCs with their mode and
// merges all commit ports into a single
// valid/ready trace stream
// --------------------------------------

`timescale 1ns/1ps

module commit_tracer #(
  parameter  int unsigned NrCommitPorts = 2,
  parameter  int unsigned FifoDepth     = 16,
  // Port number width, at least one bit
  localparam int unsigned PortIdxWidth  = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Commit ports
  input  logic [NrCommitPorts-1:0]                         commit_valid_i,
  output logic [NrCommitPorts-1:0]                         commit_ready_o,
  input  logic [NrCommitPorts-1:0][trace_pkg::PcWidth-1:0] commit_pc_i,
  input  logic [NrCommitPorts-1:0]                         commit_ex_i,
  input  trace_pkg::priv_lvl_e                             priv_lvl_i,
  input  logic                                             debug_mode_i,
  // Trace stream
  output logic                                             trace_valid_o,
  input  logic                                             trace_ready_i,
  output logic [trace_pkg::PcWidth-1:0]                    trace_pc_o,
  output trace_pkg::trace_mode_e                           trace_mode_o,
  output logic [PortIdxWidth-1:0]                          trace_port_o
);

  import trace_pkg::*;

  // Filter <-> FIFOs
  logic         [NrCommitPorts-1:0] fifo_full;
  logic         [NrCommitPorts-1:0] fifo_push;
  trace_entry_t [NrCommitPorts-1:0] fifo_entry;
  // FIFOs <-> arbiter
  logic         [NrCommitPorts-1:0] fifo_not_empty;
  logic         [NrCommitPorts-1:0] fifo_pop;
  trace_entry_t [NrCommitPorts-1:0] fifo_head;

  // --------------------------------------
  // Input side
  // --------------------------------------

  commit_filter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_commit_filter (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_valid_i ( commit_valid_i ),
    .commit_ex_i    ( commit_ex_i    ),
    .commit_pc_i    ( commit_pc_i    ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .commit_ready_o ( commit_ready_o ),
    .fifo_full_i    ( fifo_full      ),
    .push_o         ( fifo_push      ),
    .entry_o        ( fifo_entry     )
  );

  // --------------------------------------
  // Per port buffering
  // --------------------------------------

  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_trace_fifo
    trace_fifo #(
      .T     ( trace_entry_t ),
      .Depth ( FifoDepth     )
    ) i_trace_fifo (
      .clk_i       ( clk_i             ),
      .rst_ni      ( rst_ni            ),
      .push_i      ( fifo_push[i]      ),
      .data_i      ( fifo_entry[i]     ),
      .full_o      ( fifo_full[i]      ),
      .pop_i       ( fifo_pop[i]       ),
      .not_empty_o ( fifo_not_empty[i] ),
      .data_o      ( fifo_head[i]      )
    );
  end

  // --------------------------------------
  // Output side
  // --------------------------------------

  trace_arbiter #(
    .NrCommitPorts ( NrCommitPorts ),
    .PortIdxWidth  ( PortIdxWidth  )
  ) i_trace_arbiter (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .not_empty_i   ( fifo_not_empty ),
    .head_i        ( fifo_head      ),
    .pop_o         ( fifo_pop       ),
    .trace_valid_o ( trace_valid_o  ),
    .trace_ready_i ( trace_ready_i  ),
    .trace_pc_o    ( trace_pc_o     ),
    .trace_mode_o  ( trace_mode_o   ),
    .trace_port_o  ( trace_port_o   )
  );

endmodule

// ==== tb_clock_gen.sv ====
// --------------------------------------
// Testbench clock and reset
// Free running clock, reset held low for
// a fixed number of cycles
// --------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge, like the stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb_commit_tracer.sv ====
// --------------------------------------
// Commit tracer testbench
// Random commits and back-pressure with
// per-port reference queues and a watchdog
// --------------------------------------

`timescale 1ns/1ps

module tb_commit_tracer;

  import trace_pkg::*;

  localparam int unsigned NrPorts        = 2;
  localparam int unsigned Depth          = 4;
  localparam int unsigned ClkPeriodNs    = 100;
  localparam int unsigned Seed           = 88598;
  localparam int unsigned NumCommits     = 400;
  localparam int unsigned ValidPct       = 70;
  localparam int unsigned StallPct       = 40;
  localparam int unsigned WatchdogCycles = NumCommits * 20;

  logic                             clk;
  logic                             rst_n;
  logic [NrPorts-1:0]               commit_valid;
  logic [NrPorts-1:0]               commit_ready;
  logic [NrPorts-1:0][PcWidth-1:0]  commit_pc;
  logic [NrPorts-1:0]               commit_ex;
  priv_lvl_e                        priv_lvl;
  logic                             debug_mode;
  logic                             trace_valid;
  logic                             trace_ready;
  logic [PcWidth-1:0]               trace_pc;
  trace_mode_e                      trace_mode;
  logic [0:0]                       trace_port;

  // Reference model, one queue per port
  logic [PcWidth-1:0] exp_pc_q   [NrPorts][$];
  trace_mode_e        exp_mode_q [NrPorts][$];

  logic [NrPorts-1:0] accepted;
  int unsigned        errors;
  int unsigned        checks;
  int unsigned        commits;
  int unsigned        dropped;
  int unsigned        traced;

  // Output seen stalled on the previous edge
  bit                 stall_seen;
  logic [PcWidth-1:0] stall_pc;
  trace_mode_e        stall_mode;
  logic [0:0]         stall_port;

  tb_clock_gen #(
    .PeriodNs    ( ClkPeriodNs ),
    .ResetCycles ( 8           )
  ) i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_tracer #(
    .NrCommitPorts ( NrPorts ),
    .FifoDepth     ( Depth   )
  ) dut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_valid_i ( commit_valid ),
    .commit_ready_o ( commit_ready ),
    .commit_pc_i    ( commit_pc    ),
    .commit_ex_i    ( commit_ex    ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .trace_valid_o  ( trace_valid  ),
    .trace_ready_i  ( trace_ready  ),
    .trace_pc_o     ( trace_pc     ),
    .trace_mode_o   ( trace_mode   ),
    .trace_port_o   ( trace_port   )
  );

  // --------------------------------------
  // Model helpers
  // --------------------------------------

  // Debug wins, otherwise the privilege level decides
  function automatic trace_mode_e expected_mode(input logic dbg, input priv_lvl_e lvl);
    if (dbg) begin
      return MODE_D;
    end
    case (lvl)
      PRIV_LVL_S: return MODE_S;
      PRIV_LVL_U: return MODE_U;
      default:    return MODE_M;
    endcase
  endfunction

  function automatic bit queues_empty();
    for (int i = 0; i < NrPorts; i++) begin
      if (exp_pc_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic log_mismatch(input string name, input logic [PcWidth-1:0] got,
                              input logic [PcWidth-1:0] exp);
    errors++;
    $display("error: %0t ns %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic log_unexpected(input int port);
    errors++;
    $display("Output item on port %0d at %0t ns while no stored commit is pending",
             port, $time);
  endtask

  // --------------------------------------
  // Per edge checks
  // --------------------------------------

  task automatic check_reset_state();
    checks += 2;
    assert (trace_valid == 1'b0)
      else log_mismatch("trace_valid_o", PcWidth'(trace_valid), '0);
    assert (commit_ready == '1)
      else log_mismatch("commit_ready_o", PcWidth'(commit_ready), PcWidth'({NrPorts{1'b1}}));
  endtask

  // Pending items minus the one held at the output give the FIFO fill
  task automatic check_ready();
    int held;
    int fill;
    bit exp_ready;
    for (int i = 0; i < NrPorts; i++) begin
      held      = (trace_valid && int'(trace_port) == i) ? 1 : 0;
      fill      = exp_pc_q[i].size() - held;
      exp_ready = (fill < int'(Depth));
      checks++;
      assert (commit_ready[i] == exp_ready)
        else log_mismatch($sformatf("commit_ready_o[%0d]", i),
                          PcWidth'(commit_ready[i]), PcWidth'(exp_ready));
    end
  endtask

  task automatic check_outputs();
    int                 p;
    logic [PcWidth-1:0] exp_pc;
    trace_mode_e        exp_mode;
    // Held item from a stalled edge
    if (stall_seen) begin
      checks += 4;
      assert (trace_valid)
        else log_mismatch("trace_valid_o", PcWidth'(trace_valid), PcWidth'(1'b1));
      assert (trace_pc == stall_pc)
        else log_mismatch("trace_pc_o", trace_pc, stall_pc);
      assert (trace_mode == stall_mode)
        else log_mismatch("trace_mode_o", PcWidth'(trace_mode), PcWidth'(stall_mode));
      assert (trace_port == stall_port)
        else log_mismatch("trace_port_o", PcWidth'(trace_port), PcWidth'(stall_port));
    end
    stall_seen = trace_valid && !trace_ready;
    stall_pc   = trace_pc;
    stall_mode = trace_mode;
    stall_port = trace_port;

    if (trace_valid && trace_ready) begin
      p = int'(trace_port);
      checks++;
      assert (exp_pc_q[p].size() != 0)
        else log_unexpected(p);
      if (exp_pc_q[p].size() != 0) begin
        exp_pc   = exp_pc_q[p].pop_front();
        exp_mode = exp_mode_q[p].pop_front();
        traced++;
        checks += 2;
        assert (trace_pc == exp_pc)
          else log_mismatch("trace_pc_o", trace_pc, exp_pc);
        assert (trace_mode == exp_mode)
          else log_mismatch("trace_mode_o", PcWidth'(trace_mode), PcWidth'(exp_mode));
      end
    end
  endtask

  // Trapping commits are handshaked but never queued
  task automatic record_commits();
    for (int i = 0; i < NrPorts; i++) begin
      accepted[i] = commit_valid[i] && commit_ready[i];
      if (accepted[i]) begin
        commits++;
        if (commit_ex[i]) begin
          dropped++;
        end else begin
          exp_pc_q[i].push_back(commit_pc[i]);
          exp_mode_q[i].push_back(expected_mode(debug_mode, priv_lvl));
        end
      end
    end
  endtask

  // --------------------------------------
  // Stimulus
  // --------------------------------------

  task automatic drive_stimulus(input bit active);
    for (int i = 0; i < NrPorts; i++) begin
      // A pending commit holds until it is taken
      if (!(commit_valid[i] && !accepted[i])) begin
        if (active) begin
          commit_valid[i] <= ($urandom_range(99) < ValidPct);
          commit_pc[i]    <= {$urandom, $urandom & 32'hffff_fffc};
          commit_ex[i]    <= ($urandom_range(4) == 0);
        end else begin
          commit_valid[i] <= 1'b0;
        end
      end
    end
    case ($urandom_range(2))
      0:       priv_lvl <= PRIV_LVL_U;
      1:       priv_lvl <= PRIV_LVL_S;
      default: priv_lvl <= PRIV_LVL_M;
    endcase
    debug_mode  <= ($urandom_range(7) == 0);
    trace_ready <= active ? ($urandom_range(99) >= StallPct) : 1'b1;
  endtask

  task automatic run_cycle(input bit active);
    check_ready();
    check_outputs();
    record_commits();
    drive_stimulus(active);
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------

  initial begin : main
    commit_valid = '0;
    commit_pc    = '0;
    commit_ex    = '0;
    priv_lvl     = PRIV_LVL_M;
    debug_mode   = 1'b0;
    trace_ready  = 1'b0;
    accepted     = '0;
    errors       = 0;
    checks       = 0;
    commits      = 0;
    dropped      = 0;
    traced       = 0;
    stall_seen   = 1'b0;
    void'($urandom(Seed));

    // First edge only loads the reset values
    @(posedge clk);
    do begin
      @(posedge clk);
      check_reset_state();
    end while (!rst_n);
    drive_stimulus(1'b1);

    while (commits < NumCommits) begin
      @(posedge clk);
      run_cycle(1'b1);
    end

    // Drain with the output always ready
    while (!queues_empty() || trace_valid || commit_valid != '0) begin
      @(posedge clk);
      run_cycle(1'b0);
    end
    repeat (5) begin
      @(posedge clk);
      run_cycle(1'b0);
    end

    $display("Summary: %0d checks, %0d errors, %0d commits, %0d dropped, %0d traced",
             checks, errors, commits, dropped, traced);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Ends a run whose queues never drain
  initial begin : watchdog
    #(WatchdogCycles * ClkPeriodNs);
    $display("Watchdog expired after %0d cycles before the trace queues drained",
             WatchdogCycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
trace_pkg.sv
commit_filter.sv
trace_fifo.sv
trace_arbiter.sv
commit_tracer.sv
tb_clock_gen.sv
tb_commit_tracer.sv

// ==== Makefile ====
TOP = tb_commit_tracer

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
